// File: Makefile
VERILATOR ?= verilator
TOP       ?= radar_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+design
+incdir+dv
design/radar_pkg.sv
design/pulse_detect.sv
design/azimuth_track.sv
design/sweep_control.sv
design/sample_select.sv
design/output_handshake.sv
design/radar_top.sv
dv/radar_tb.sv

// File: design/azimuth_track.sv
`timescale 1ns/10ps
`include "radar_settings.svh"

// acp and arp bookkeeping so the host can place each sweep in azimuth
module azimuth_track
(
   input  logic                    clk64,
   input  logic                    rx_dsp_reset,
   input  logic                    acp_strobe,   // azimuth step seen
   input  logic                    arp_strobe,   // heading mark seen
   output logic [`RADAR_CNT_W-1:0] n_acps,
   output logic [`RADAR_CNT_W-1:0] n_arps,
   output logic [`RADAR_CNT_W-1:0] acp_at_arp   // acp count at latest heading mark
);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         n_acps     <= '0;
         n_arps     <= '0;
         acp_at_arp <= '0;
      end
      else
      begin
         if (acp_strobe)
            n_acps <= n_acps + 1'b1;
         if (arp_strobe)
         begin
            n_arps     <= n_arps + 1'b1;
            // old value of n_acps, so a coincident acp is not included
            acp_at_arp <= n_acps;
         end
      end
   end

endmodule

// File: design/output_handshake.sv
`timescale 1ns/10ps
`include "radar_settings.svh"

// two-word queue drained over a four-phase req/ack port
module output_handshake
   import radar_pkg::*;
(
   input  logic        clk64,
   input  logic        rx_dsp_reset,
   input  logic        header_valid,
   input  radar_word_u header_word,
   input  logic        data_valid,
   input  radar_word_u data_word,
   input  logic        out_ack,
   input  logic        clear_overrun,
   output radar_word_u out_word,
   output logic        out_req,
   output logic        overrun   // sticky, a word was dropped
);

   radar_word_u mem [2];
   logic        wr_ptr;
   logic        rd_ptr;
   logic [1:0]  fill;     // words held, 0 to 2
   logic        push;
   logic        pop;
   logic        drop;
   radar_word_u in_word;

   assign in_word  = header_valid ? header_word : data_word;  // never both at once
   assign drop     = (header_valid | data_valid) & (fill == 2'd2);
   assign push     = (header_valid | data_valid) & (fill != 2'd2);
   assign pop      = out_req & out_ack;  // word leaves as req drops
   assign out_word = mem[rd_ptr];        // head stays put while req is high

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         fill    <= 2'd0;
         out_req <= 1'b0;
         overrun <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         fill <= fill + {1'b0, push} - {1'b0, pop};
         if (pop)
            out_req <= 1'b0;
         else if (!out_req && !out_ack && (fill != 2'd0))
            out_req <= 1'b1;  // wait for ack low before the next word
         if (drop)
            overrun <= 1'b1;  // a new drop wins over clear
         else if (clear_overrun)
            overrun <= 1'b0;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (push)
         mem[wr_ptr] <= in_word;
   end

endmodule

// File: design/pulse_detect.sv
`timescale 1ns/10ps
`include "radar_settings.svh"

// level crossing to single strobe, with hysteresis between excite and relax
module pulse_detect
#(
   parameter int width = 12
)
(
   input  logic                    clk64,
   input  logic                    rx_dsp_reset,
   input  logic [width-1:0]        signal,
   input  logic [width-1:0]        excite,   // fire at or above this
   input  logic [width-1:0]        relax,    // re-arm at or below this
   output logic                    strobe,   // one clk64 wide
   output logic [`RADAR_CNT_W-1:0] count     // detections since reset
);

   logic armed;  // waiting for the next excursion past excite

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         armed  <= 1'b1;  // first crossing after reset counts
         strobe <= 1'b0;
         count  <= '0;
      end
      else
      begin
         strobe <= 1'b0;
         if (armed && (signal >= excite))
         begin
            strobe <= 1'b1;
            count  <= count + 1'b1;
            armed  <= 1'b0;  // stay quiet until signal drops to relax
         end
         else if (signal <= relax)
            armed <= 1'b1;
      end
   end

endmodule

// File: design/radar_pkg.sv
`include "radar_settings.svh"

package radar_pkg;

   // header view, first word of every sweep
   typedef struct packed
   {
      logic                     is_header;  // always 1 here
      logic [`RADAR_WORD_W-2:0] sweep_id;   // low bits of trigger count at sweep start
   } radar_hdr_t;

   // data view, one word per decimated sample
   typedef struct packed
   {
      logic                    is_header;   // always 0 here
      logic [2:0]              src;         // RADAR_SRC_* tag
      logic [`RADAR_ADC_W-1:0] value;       // sample, 1-bit inputs zero extended
   } radar_dat_t;

   // one output word; bit 15 says which view applies
   typedef union packed
   {
      radar_hdr_t hdr;
      radar_dat_t dat;
   } radar_word_u;

endpackage

// File: design/radar_settings.svh
`ifndef RADAR_SETTINGS_SVH
`define RADAR_SETTINGS_SVH

// datapath widths
`define RADAR_ADC_W   12   // video and trigger adc samples
`define RADAR_WORD_W  16   // one word on the output port
`define RADAR_CNT_W   16   // pulse counters and n_samples
`define RADAR_RATE_W  16   // decimation rate
`define RADAR_MODE_W  3

// digitizer modes; only mode 0 waits for a trigger
`define RADAR_MODE_PULSED     3'd0  // trigger-synced video
`define RADAR_MODE_VIDEO      3'd1  // raw video, free running
`define RADAR_MODE_TRIG       3'd2  // raw trigger adc
`define RADAR_MODE_ARP        3'd3  // raw heading input
`define RADAR_MODE_ACP        3'd4  // raw azimuth step input
`define RADAR_MODE_INTERLEAVE 3'd5  // all four raw sources in turn

// source tags carried in the data words
`define RADAR_SRC_VIDEO 3'd0
`define RADAR_SRC_TRIG  3'd1
`define RADAR_SRC_ARP   3'd2
`define RADAR_SRC_ACP   3'd3

`endif

// File: design/radar_top.sv
`timescale 1ns/10ps
`include "radar_settings.svh"

// pulse digitizer for a marine radar
module radar_top
   import radar_pkg::*;
(
   input  logic                     clk64,
   input  logic                     rx_dsp_reset,
   input  logic [`RADAR_ADC_W-1:0]  video,
   input  logic [`RADAR_ADC_W-1:0]  trigger,
   input  logic                     arp,          // heading mark
   input  logic                     acp,          // azimuth step
   input  logic [`RADAR_MODE_W-1:0] mode,
   input  logic                     vid_negate,
   input  logic [`RADAR_RATE_W-1:0] decim_rate,
   input  logic [`RADAR_CNT_W-1:0]  n_samples,
   input  logic [`RADAR_ADC_W-1:0]  trig_excite,
   input  logic [`RADAR_ADC_W-1:0]  trig_relax,
   input  logic                     out_ack,
   input  logic                     clear_overrun,
   output radar_word_u              out_word,
   output logic                     out_req,
   output logic                     overrun,
   output logic                     sweep_active,
   output logic [`RADAR_CNT_W-1:0]  n_acps,
   output logic [`RADAR_CNT_W-1:0]  n_arps,
   output logic [`RADAR_CNT_W-1:0]  acp_at_arp
);

   logic                    trig_strobe;
   logic [`RADAR_CNT_W-1:0] trig_count;   // triggers since reset, feeds sweep_id
   logic                    arp_strobe;
   logic                    acp_strobe;
   logic                    sample_strobe;
   logic [1:0]              phase;
   logic                    header_valid;
   radar_word_u             header_word;
   logic                    data_valid;
   radar_word_u             data_word;

   pulse_detect #(.width(`RADAR_ADC_W)) trig_detect
     (.clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .signal(trigger),
      .excite(trig_excite), .relax(trig_relax), .strobe(trig_strobe), .count(trig_count));

   // digital inputs, fixed thresholds; counts kept in azimuth_track
   pulse_detect #(.width(1)) arp_detect
     (.clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .signal(arp),
      .excite(1'b1), .relax(1'b0), .strobe(arp_strobe), .count());

   pulse_detect #(.width(1)) acp_detect
     (.clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .signal(acp),
      .excite(1'b1), .relax(1'b0), .strobe(acp_strobe), .count());

   azimuth_track azimuth_track
     (.clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .acp_strobe(acp_strobe),
      .arp_strobe(arp_strobe), .n_acps(n_acps), .n_arps(n_arps), .acp_at_arp(acp_at_arp));

   sweep_control sweep_control
     (.clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .mode(mode), .trig_strobe(trig_strobe),
      .trig_count(trig_count), .decim_rate(decim_rate), .n_samples(n_samples),
      .sweep_active(sweep_active), .sample_strobe(sample_strobe), .phase(phase),
      .header_valid(header_valid), .header_word(header_word));

   sample_select sample_select
     (.clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .mode(mode), .vid_negate(vid_negate),
      .sample_strobe(sample_strobe), .phase(phase), .video(video), .trigger(trigger),
      .arp(arp), .acp(acp), .data_valid(data_valid), .data_word(data_word));

   output_handshake output_handshake
     (.clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .header_valid(header_valid),
      .header_word(header_word), .data_valid(data_valid), .data_word(data_word),
      .out_ack(out_ack), .clear_overrun(clear_overrun), .out_word(out_word),
      .out_req(out_req), .overrun(overrun));

endmodule

// File: design/sample_select.sv
`timescale 1ns/10ps
`include "radar_settings.svh"

// picks the source for the current mode and builds a tagged data word
module sample_select
   import radar_pkg::*;
(
   input  logic                     clk64,
   input  logic                     rx_dsp_reset,
   input  logic [`RADAR_MODE_W-1:0] mode,
   input  logic                     vid_negate,    // pulsed mode only
   input  logic                     sample_strobe,
   input  logic [1:0]               phase,
   input  logic [`RADAR_ADC_W-1:0]  video,
   input  logic [`RADAR_ADC_W-1:0]  trigger,
   input  logic                     arp,
   input  logic                     acp,
   output logic                     data_valid,
   output radar_word_u              data_word
);

   logic [2:0]              sel_src;
   logic [`RADAR_ADC_W-1:0] sel_value;

   always_comb
   begin
      case (mode)
         `RADAR_MODE_TRIG:       sel_src = `RADAR_SRC_TRIG;
         `RADAR_MODE_ARP:        sel_src = `RADAR_SRC_ARP;
         `RADAR_MODE_ACP:        sel_src = `RADAR_SRC_ACP;
         `RADAR_MODE_INTERLEAVE: sel_src = {1'b0, phase};  // slot order matches tag order
         default:                sel_src = `RADAR_SRC_VIDEO;  // pulsed and raw video
      endcase
      case (sel_src)
         `RADAR_SRC_TRIG: sel_value = trigger;
         `RADAR_SRC_ARP:  sel_value = {{(`RADAR_ADC_W-1){1'b0}}, arp};
         `RADAR_SRC_ACP:  sel_value = {{(`RADAR_ADC_W-1){1'b0}}, acp};
         default:
         begin
            if (vid_negate && (mode == `RADAR_MODE_PULSED))
               sel_value = {`RADAR_ADC_W{1'b1}} - video;  // full scale minus video
            else
               sel_value = video;
         end
      endcase
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         data_valid <= 1'b0;
      else
         data_valid <= sample_strobe;
   end

   // payload only, qualified by data_valid
   always_ff @(posedge clk64)
   begin
      if (sample_strobe)
      begin
         data_word.dat.is_header <= 1'b0;
         data_word.dat.src       <= sel_src;
         data_word.dat.value     <= sel_value;
      end
   end

endmodule

// File: design/sweep_control.sv
`timescale 1ns/10ps
`include "radar_settings.svh"

// starts sweeps, runs the decimation and sample counters, issues headers
module sweep_control
   import radar_pkg::*;
(
   input  logic                     clk64,
   input  logic                     rx_dsp_reset,
   input  logic [`RADAR_MODE_W-1:0] mode,
   input  logic                     trig_strobe,
   input  logic [`RADAR_CNT_W-1:0]  trig_count,
   input  logic [`RADAR_RATE_W-1:0] decim_rate,   // at least 4
   input  logic [`RADAR_CNT_W-1:0]  n_samples,    // at least 1
   output logic                     sweep_active,
   output logic                     sample_strobe,
   output logic [1:0]               phase,        // interleave slot of current sample
   output logic                     header_valid,
   output radar_word_u              header_word
);

   logic [`RADAR_RATE_W-1:0] decim_cnt;   // cycles since last sample strobe
   logic [`RADAR_CNT_W-1:0]  sample_cnt;  // strobes issued this sweep
   logic [`RADAR_WORD_W-2:0] sweep_id;
   logic                     first_cycle; // first cycle of a sweep
   logic                     start;
   logic                     decim_hit;

   // raw modes restart whenever idle, pulsed mode waits for a trigger
   assign start     = ~sweep_active & ((mode != `RADAR_MODE_PULSED) | trig_strobe);
   assign decim_hit = sweep_active & (decim_cnt == decim_rate - 1'b1);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         sweep_active  <= 1'b0;
         first_cycle   <= 1'b0;
         header_valid  <= 1'b0;
         sample_strobe <= 1'b0;
         decim_cnt     <= '0;
         sample_cnt    <= '0;
         phase         <= 2'd0;
      end
      else
      begin
         first_cycle   <= start;
         header_valid  <= first_cycle;  // header goes out one cycle into the sweep
         sample_strobe <= decim_hit;
         if (start)
         begin
            sweep_active <= 1'b1;
            decim_cnt    <= '0;
            sample_cnt   <= '0;
            phase        <= 2'd0;  // interleave always opens on video
         end
         else if (sweep_active)
         begin
            if (decim_hit)
            begin
               decim_cnt  <= '0;
               sample_cnt <= sample_cnt + 1'b1;
            end
            else
               decim_cnt <= decim_cnt + 1'b1;
            if (sample_strobe)
               phase <= phase + 2'd1;
            if (sample_strobe && (sample_cnt == n_samples))
               sweep_active <= 1'b0;  // last data word strobed
         end
      end
   end

   // triggers in the start cycle are already in trig_count
   always_ff @(posedge clk64)
   begin
      if (start)
         sweep_id <= trig_count[`RADAR_WORD_W-2:0];
   end

   always_comb
   begin
      header_word              = '0;
      header_word.hdr.is_header = 1'b1;
      header_word.hdr.sweep_id  = sweep_id;
   end

endmodule

// File: dv/radar_tb_table.svh
`ifndef RADAR_TB_TABLE_SVH
`define RADAR_TB_TABLE_SVH

// columns: name, mode, negate, decim_rate, n_samples, video, trigger peak or level,
// trigger level between excursions, excursions, arp, acp, ack delay,
// words to collect, overrun expected
task automatic load_table();
   add_row("pulsed",        3'd0, 1'b0, 16'd8, 16'd6, 12'h5a3, 12'd3000, 12'd0,
           2'd1, 1'b0, 1'b0, 16'd1, 16'd7, 1'b0);
   add_row("pulsed_negate", 3'd0, 1'b1, 16'd8, 16'd6, 12'h0f0, 12'd3000, 12'd0,
           2'd1, 1'b0, 1'b0, 16'd1, 16'd7, 1'b0);
   add_row("hysteresis",    3'd0, 1'b0, 16'd8, 16'd6, 12'h2c7, 12'd3000, 12'd1000,
           2'd2, 1'b0, 1'b0, 16'd1, 16'd7, 1'b0);   // mid level stays above relax
   add_row("raw_video",     3'd1, 1'b1, 16'd8, 16'd3, 12'h321, 12'h123, 12'd0,
           2'd0, 1'b0, 1'b0, 16'd1, 16'd8, 1'b0);   // negate ignored outside mode 0
   add_row("raw_trigger",   3'd2, 1'b0, 16'd8, 16'd3, 12'h321, 12'h456, 12'd0,
           2'd0, 1'b0, 1'b0, 16'd1, 16'd8, 1'b0);
   add_row("raw_arp",       3'd3, 1'b0, 16'd8, 16'd3, 12'h321, 12'h456, 12'd0,
           2'd0, 1'b1, 1'b0, 16'd1, 16'd8, 1'b0);
   add_row("raw_acp",       3'd4, 1'b0, 16'd8, 16'd3, 12'h321, 12'h456, 12'd0,
           2'd0, 1'b0, 1'b1, 16'd1, 16'd8, 1'b0);
   add_row("interleave",    3'd5, 1'b0, 16'd8, 16'd6, 12'h7e1, 12'h19a, 12'd0,
           2'd0, 1'b1, 1'b0, 16'd1, 16'd14, 1'b0);
   add_row("backpressure",  3'd1, 1'b0, 16'd4, 16'd4, 12'h0aa, 12'h0, 12'd0,
           2'd0, 1'b0, 1'b0, 16'd400, 16'd2, 1'b1);  // ack far slower than a sweep
endtask

`endif

// File: dv/radar_tb.sv
`timescale 1ns/10ps
`include "radar_settings.svh"

module radar_tb
   import radar_pkg::*;
;
   localparam int wait_limit = 2000;  // cycles per wait loop

   typedef struct packed
   {
      logic [2:0]  mode;
      logic        neg;
      logic [15:0] rate;
      logic [15:0] nsamp;
      logic [11:0] video;
      logic [11:0] trig;
      logic [11:0] mid;
      logic [1:0]  n_exc;
      logic        arp;
      logic        acp;
      logic [15:0] ack_delay;
      logic [15:0] n_words;
      logic        exp_ovr;
   } row_t;

   logic clk64, rx_dsp_reset;
   logic [11:0] video, trigger;
   logic arp, acp, vid_negate, out_ack, clear_overrun;
   logic [2:0] mode;
   logic [15:0] decim_rate, n_samples;
   logic [11:0] trig_excite, trig_relax;
   radar_word_u out_word;
   logic out_req, overrun, sweep_active;
   logic [15:0] n_acps, n_arps, acp_at_arp;

   row_t  rows[$];
   string names[$];
   string cur_name;
   int    errs;
   int    n_tests = 0;
   int    n_failed = 0;
   logic [31:0] lfsr = 32'he6bc;

   radar_top DUT (.*);

   initial
   begin
      clk64 = 1'b0;
      forever #10 clk64 = ~clk64;
   end

   task automatic add_row(input string name, input logic [2:0] m, input logic neg,
                          input logic [15:0] rate, input logic [15:0] ns,
                          input logic [11:0] vid, input logic [11:0] trg,
                          input logic [11:0] mid, input logic [1:0] nexc, input logic a,
                          input logic c, input logic [15:0] dly, input logic [15:0] nw,
                          input logic ovr);
      row_t r;
      r = '{m, neg, rate, ns, vid, trg, mid, nexc, a, c, dly, nw, ovr};
      rows.push_back(r);
      names.push_back(name);
   endtask

   `include "radar_tb_table.svh"

   // galois lfsr stepped once per bit
   function automatic logic lfsr_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
         lfsr = lfsr ^ 32'ha300_0000;
      return b;
   endfunction

   task automatic next_cycle();
      @(posedge clk64);
      #2;  // drive and sample clear of the edge
   endtask

   task automatic check_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      if (exp_v !== act_v)
      begin
         $display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
         errs++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("%s: %s", cur_name, msg);
      errs++;
   endtask

   // expected word idx of the stream with a header first in every sweep
   function automatic logic [15:0] expected_word(input row_t r, input int idx);
      int k;
      logic [2:0] src;
      logic [11:0] val;
      k = idx % (r.nsamp + 1);
      if (k == 0)
         return {1'b1, 15'((r.mode == 3'd0) ? 1 : 0)};  // one trigger seen in mode 0
      k = k - 1;
      case (r.mode)
         3'd2: src = 3'd1;
         3'd3: src = 3'd2;
         3'd4: src = 3'd3;
         3'd5: src = 3'(k % 4);
         default: src = 3'd0;
      endcase
      case (src)
         3'd1: val = r.trig;
         3'd2: val = {11'd0, r.arp};
         3'd3: val = {11'd0, r.acp};
         default: val = (r.mode == 3'd0 && r.neg) ? 12'hfff - r.video : r.video;
      endcase
      return {1'b0, src, val};
   endfunction

   task automatic recv_word(input int delay, output logic [15:0] w, output bit ok);
      int cnt;
      ok  = 0;
      w   = '0;
      cnt = 0;
      while (!out_req && cnt < wait_limit)
      begin
         next_cycle();
         cnt++;
      end
      if (!out_req)
      begin
         note_failure("the DUT never raised out_req");
         return;
      end
      w = out_word;
      repeat (delay) next_cycle();
      check_value("word held under out_req", w, out_word);
      out_ack = 1'b1;
      cnt = 0;
      while (out_req && cnt < wait_limit)
      begin
         next_cycle();
         cnt++;
      end
      out_ack = 1'b0;
      if (out_req)
         note_failure("out_req stayed high after out_ack");
      else
         ok = 1;
   endtask

   task automatic drive_trigger(input row_t r);
      if (r.mode != 3'd0)
         return;
      next_cycle();
      trigger = r.trig;  // excursion past excite
      repeat (3) next_cycle();
      if (r.n_exc == 2'd2)
      begin
         trigger = r.mid;
         repeat (r.rate * r.nsamp + 20) next_cycle();  // past the end of the sweep
         trigger = r.trig;
         repeat (3) next_cycle();
      end
      trigger = 12'd0;
   endtask

   task automatic apply_reset();
      rx_dsp_reset = 1'b1;
      repeat (8) next_cycle();
      rx_dsp_reset = 1'b0;
   endtask

   task automatic run_row(input int i);
      row_t r;
      logic [15:0] got[$];
      logic [15:0] w;
      bit ok;
      int cnt;
      int total;
      r = rows[i];
      cur_name = names[i];
      errs = 0;
      mode = r.mode;
      vid_negate = r.neg;
      decim_rate = r.rate;
      n_samples = r.nsamp;
      video = r.video;
      trigger = (r.mode == 3'd0) ? 12'd0 : r.trig;
      arp = r.arp;
      acp = r.acp;
      apply_reset();
      fork
         drive_trigger(r);
         begin
            ok = 1;
            while (ok && got.size() < r.n_words)
            begin
               recv_word(r.ack_delay, w, ok);
               if (ok)
                  got.push_back(w);
            end
         end
      join
      foreach (got[j])
         check_value($sformatf("word %0d", j), expected_word(r, j), got[j]);
      check_value("overrun", r.exp_ovr, overrun);
      if (r.exp_ovr)
      begin
         mode = 3'd0;  // no trigger so sweeps stop
         cnt = 0;
         while (sweep_active && cnt < wait_limit)
         begin
            next_cycle();
            cnt++;
         end
         if (sweep_active)
            note_failure("sweep never ended after leaving raw mode");
         cnt = 0;
         total = 0;
         while (cnt < 20 && total < wait_limit)  // drain whatever the queue still holds
         begin
            next_cycle();
            cnt++;
            total++;
            if (out_req)
            begin
               recv_word(0, w, ok);
               cnt = 0;
            end
         end
         if (cnt < 20)
            note_failure("the queue kept sending words after sweeps stopped");
         clear_overrun = 1'b1;
         next_cycle();
         clear_overrun = 1'b0;
         next_cycle();
         check_value("overrun after clear", 0, overrun);
      end
      else if (r.mode == 3'd0)
      begin
         // second excursion or a retrigger must not start another sweep
         repeat (2 * r.rate * r.nsamp + 40)
         begin
            next_cycle();
            if (out_req)
            begin
               note_failure("an extra word arrived after the sweep");
               break;
            end
         end
      end
   endtask

   task automatic run_azimuth();
      int acps;
      int arps;
      int at_arp;
      int gap;
      logic coincide;
      cur_name = "azimuth";
      errs = 0;
      acps = 0;
      arps = 0;
      at_arp = 0;
      mode = 3'd0;
      trigger = 12'd0;
      arp = 1'b0;
      acp = 1'b0;
      apply_reset();
      repeat (40)
      begin
         coincide = lfsr_bit();
         acp = 1'b1;
         arp = coincide;
         if (coincide)
         begin
            arps++;
            at_arp = acps;  // heading mark on an acp takes the count before it
         end
         acps++;
         next_cycle();
         acp = 1'b0;
         arp = 1'b0;
         gap = 2 + {lfsr_bit(), lfsr_bit(), lfsr_bit()};
         for (int j = 0; j < gap; j++)
         begin
            arp = 1'b0;
            if (j == 0 && !coincide && lfsr_bit())
            begin
               arp = 1'b1;  // heading mark between two acps
               arps++;
               at_arp = acps;
            end
            next_cycle();
         end
         arp = 1'b0;
      end
      repeat (5) next_cycle();
      check_value("n_acps", acps, n_acps);
      check_value("n_arps", arps, n_arps);
      check_value("acp_at_arp", at_arp, acp_at_arp);
   endtask

   task automatic report_test();
      n_tests++;
      if (errs != 0)
         n_failed++;
      $display("test %s: %s", cur_name, (errs == 0) ? "ok" : "FAILED");
   endtask

   initial
   begin
      rx_dsp_reset = 1'b1;
      video = '0;
      trigger = '0;
      arp = 1'b0;
      acp = 1'b0;
      mode = 3'd0;
      vid_negate = 1'b0;
      decim_rate = 16'd8;
      n_samples = 16'd1;
      trig_excite = 12'd2000;
      trig_relax = 12'd500;
      out_ack = 1'b0;
      clear_overrun = 1'b0;
      load_table();
      foreach (rows[i])
      begin
         run_row(i);
         report_test();
      end
      run_azimuth();
      report_test();
      $display("%0d tests run, %0d failed", n_tests, n_failed);
      if (n_failed == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule
